//--- verilog/debug_pkg.sv
`default_nettype none

package debug_pkg;

  //////////////////////////////
  // Data types
  //////////////////////////////

  typedef logic [7:0]  byte_t;   // Host link byte.
  typedef logic [31:0] word_t;   // Instruction or program word.
  typedef logic [10:0] addr_t;   // Program memory word address.
  typedef logic [15:0] pc_t;     // Reported PC.
  typedef logic [15:0] count_t;  // Enabled cycle count.

  //////////////////////////////
  // Host commands
  //////////////////////////////

  localparam byte_t CMD_SOFT_RESET = 8'h00;
  localparam byte_t CMD_LOAD       = 8'h01;
  localparam byte_t CMD_RUN_CONT   = 8'h03;
  localparam byte_t CMD_RUN_STEP   = 8'h07;

  localparam word_t HALT_WORD    = 32'h0000_0000;  // Ends a load and a run.
  localparam int    REPORT_BYTES = 8;              // PC, cycles, instruction.

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_WAIT_START,
    ST_RUN,
    ST_REPORT
  } seq_state_t;

endpackage

`default_nettype wire

//--- verilog/load_if.sv
`timescale 1ns/1ps
`default_nettype none

interface load_if import debug_pkg::*; ();

  logic  start;       // Clears the loader, one cycle.
  logic  byte_valid;  // Received byte strobe.
  byte_t byte_data;
  logic  done;        // HALT word has been written.

  modport sequencer (
    output start,
    output byte_valid,
    output byte_data,
    input  done
  );

  modport loader (
    input  start,
    input  byte_valid,
    input  byte_data,
    output done
  );

endinterface

`default_nettype wire

//--- verilog/report_if.sv
`timescale 1ns/1ps
`default_nettype none

interface report_if import debug_pkg::*; ();

  logic   start;   // Capture strobe, one cycle.
  pc_t    pc;
  count_t cycles;
  word_t  instr;
  logic   done;    // Last byte has gone out.

  modport sequencer (
    output start,
    output pc,
    output cycles,
    output instr,
    input  done
  );

  modport serializer (
    input  start,
    input  pc,
    input  cycles,
    input  instr,
    output done
  );

endinterface

`default_nettype wire

//--- verilog/program_loader.sv
`timescale 1ns/1ps
`default_nettype none

module program_loader import debug_pkg::*; (
  input  logic  i_clock,
  input  logic  i_reset,
  load_if.loader load,
  output logic  o_mem_write,
  output addr_t o_mem_addr,
  output word_t o_mem_data
);

  logic [1:0] byte_cnt;
  logic [1:0] cnt_base;
  word_t      word_reg;
  addr_t      addr_reg;
  logic       write_q;
  logic       done_q;

  // A byte may arrive together with start.
  assign cnt_base = load.start ? 2'd0 : byte_cnt;

  //////////////////////////////
  // Byte assembly
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (load.byte_valid) begin
      word_reg <= {word_reg[23:0], load.byte_data};  // MSB first.
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      byte_cnt <= 2'd0;
      addr_reg <= '0;
      write_q  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      write_q <= load.byte_valid && (cnt_base == 2'd3);  // Fourth byte in.
      done_q  <= write_q && (word_reg == HALT_WORD);

      if (load.byte_valid) begin
        byte_cnt <= cnt_base + 2'd1;  // Wraps after four.
      end else if (load.start) begin
        byte_cnt <= 2'd0;
      end

      if (load.start) begin
        addr_reg <= '0;
      end else if (write_q) begin
        addr_reg <= addr_reg + 1'b1;  // Next word slot.
      end
    end
  end

  //////////////////////////////
  // Memory side
  //////////////////////////////

  assign o_mem_write = write_q;
  assign o_mem_addr  = addr_reg;
  assign o_mem_data  = word_reg;
  assign load.done   = done_q;

  // Program must fit the memory.
  a_no_addr_wrap : assert property (
    @(posedge i_clock) disable iff (!i_reset)
    o_mem_write |-> (addr_reg != '1)
  );

endmodule

`default_nettype wire

//--- verilog/report_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module report_serializer import debug_pkg::*; #(
  parameter int TX_CREDITS = 2
) (
  input  logic i_clock,
  input  logic i_reset,
  input  logic i_tx_credit,
  report_if.serializer report,
  output logic  o_tx_valid,
  output byte_t o_tx_data
);

  localparam int CW = $clog2(TX_CREDITS + 1);
  localparam int IW = $clog2(REPORT_BYTES);

  logic [CW-1:0]             credit_cnt;
  logic [IW-1:0]             byte_idx;
  logic [REPORT_BYTES*8-1:0] shift_reg;
  logic                      busy;
  logic                      done_q;
  logic                      send;

  assign send = busy && (credit_cnt != '0);  // Hold while out of credits.

  //////////////////////////////
  // Report capture and shift
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (report.start) begin
      shift_reg <= {report.pc, report.cycles, report.instr};
    end else if (send) begin
      shift_reg <= shift_reg << 8;
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      busy     <= 1'b0;
      done_q   <= 1'b0;
      byte_idx <= '0;
    end else begin
      done_q <= 1'b0;
      if (report.start) begin
        busy     <= 1'b1;
        byte_idx <= '0;
      end else if (send) begin
        byte_idx <= byte_idx + 1'b1;
        if (byte_idx == IW'(REPORT_BYTES - 1)) begin
          busy   <= 1'b0;  // Last byte sent.
          done_q <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Transmit credits
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      credit_cnt <= CW'(TX_CREDITS);
    end else begin
      case ({send, i_tx_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // Byte out.
        2'b01:   credit_cnt <= credit_cnt + 1'b1;  // Credit back.
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  assign o_tx_valid  = send;
  assign o_tx_data   = shift_reg[REPORT_BYTES*8-1 -: 8];
  assign report.done = done_q;

  a_credit_max : assert property (
    @(posedge i_clock) disable iff (!i_reset)
    credit_cnt <= CW'(TX_CREDITS)
  );

  // New report only after the last one ended.
  a_start_when_idle : assert property (
    @(posedge i_clock) disable iff (!i_reset)
    report.start |-> !busy
  );

endmodule

`default_nettype wire

//--- verilog/debug_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module debug_sequencer import debug_pkg::*; (
  input  logic   i_clock,
  input  logic   i_reset,
  input  logic   i_rx_valid,
  input  byte_t  i_rx_data,
  input  pc_t    i_pc,
  input  word_t  i_instruction,
  load_if.sequencer   load,
  report_if.sequencer report,
  output logic   o_soft_reset,
  output logic   o_pc_enable
);

  seq_state_t state;
  seq_state_t state_next;
  logic       step_mode;     // High for step mode.
  count_t     cycle_cnt;
  logic       soft_reset_n;
  logic       load_start_q;
  logic       rep_start_q;
  logic       halt_q;        // Reported instruction was HALT.

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (i_rx_valid && (i_rx_data == CMD_LOAD)) begin
          state_next = ST_LOAD;
        end
      end
      ST_LOAD: begin
        if (load.done) begin
          state_next = ST_WAIT_START;
        end
      end
      ST_WAIT_START: begin
        if (i_rx_valid && ((i_rx_data == CMD_RUN_CONT) || (i_rx_data == CMD_RUN_STEP))) begin
          state_next = ST_RUN;
        end
      end
      ST_RUN: begin
        if (step_mode || (i_instruction == HALT_WORD)) begin
          state_next = ST_REPORT;  // One step, or HALT fetched.
        end
      end
      ST_REPORT: begin
        if (report.done) begin
          state_next = (!step_mode || halt_q) ? ST_IDLE : ST_WAIT_START;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state        <= ST_IDLE;
      step_mode    <= 1'b0;
      cycle_cnt    <= '0;
      soft_reset_n <= 1'b1;
      load_start_q <= 1'b0;
      rep_start_q  <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      state        <= state_next;
      soft_reset_n <= !((state == ST_IDLE) && i_rx_valid && (i_rx_data == CMD_SOFT_RESET));
      load_start_q <= (state == ST_IDLE) && (state_next == ST_LOAD);
      rep_start_q  <= (state == ST_RUN) && (state_next == ST_REPORT);

      if ((state == ST_WAIT_START) && (state_next == ST_RUN)) begin
        step_mode <= (i_rx_data == CMD_RUN_STEP);
      end

      if (load.done) begin
        cycle_cnt <= '0;  // New program.
      end else if (o_pc_enable) begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end

      if (rep_start_q) begin
        halt_q <= (i_instruction == HALT_WORD);
      end
    end
  end

  // Step mode gets one enabled cycle, continuous mode runs up to HALT.
  assign o_pc_enable  = (state == ST_RUN) && (step_mode || (i_instruction != HALT_WORD));
  assign o_soft_reset = soft_reset_n;  // Active low.

  assign load.start      = load_start_q;
  assign load.byte_valid = i_rx_valid && (state == ST_LOAD);
  assign load.byte_data  = i_rx_data;

  assign report.start  = rep_start_q;
  assign report.pc     = i_pc;  // Sampled by the serializer.
  assign report.cycles = cycle_cnt;
  assign report.instr  = i_instruction;

  // A step enables the PC for a single cycle.
  a_step_one_cycle : assert property (
    @(posedge i_clock) disable iff (!i_reset)
    (o_pc_enable && step_mode) |=> !o_pc_enable
  );

endmodule

`default_nettype wire

//--- verilog/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit import debug_pkg::*; #(
  parameter int TX_CREDITS = 2
) (
  input  logic  i_clock,
  input  logic  i_reset,
  input  logic  i_rx_valid,
  input  byte_t i_rx_data,
  input  logic  i_tx_credit,
  input  pc_t   i_pc,
  input  word_t i_instruction,
  output logic  o_tx_valid,
  output byte_t o_tx_data,
  output logic  o_soft_reset,
  output logic  o_mem_write,
  output addr_t o_mem_addr,
  output word_t o_mem_data,
  output logic  o_pc_enable
);

  load_if   load_bus ();
  report_if report_bus ();

  debug_sequencer u_sequencer (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_rx_valid    (i_rx_valid),
    .i_rx_data     (i_rx_data),
    .i_pc          (i_pc),
    .i_instruction (i_instruction),
    .load          (load_bus.sequencer),
    .report        (report_bus.sequencer),
    .o_soft_reset  (o_soft_reset),
    .o_pc_enable   (o_pc_enable)
  );

  program_loader u_loader (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .load        (load_bus.loader),
    .o_mem_write (o_mem_write),
    .o_mem_addr  (o_mem_addr),
    .o_mem_data  (o_mem_data)
  );

  report_serializer #(
    .TX_CREDITS (TX_CREDITS)
  ) u_serializer (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_tx_credit (i_tx_credit),
    .report      (report_bus.serializer),
    .o_tx_valid  (o_tx_valid),
    .o_tx_data   (o_tx_data)
  );

endmodule

`default_nettype wire

//--- verif/tb_debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_unit import debug_pkg::*; ();

  localparam int TX_CREDITS = 2;
  localparam int TIMEOUT    = 400;  // Cycles allowed per wait.

  typedef logic [0:REPORT_BYTES-1][7:0] report_t;

  logic  i_clock;
  logic  i_reset;
  logic  i_rx_valid;
  byte_t i_rx_data;
  logic  i_tx_credit;
  pc_t   i_pc;
  word_t i_instruction;
  logic  o_tx_valid;
  byte_t o_tx_data;
  logic  o_soft_reset;
  logic  o_mem_write;
  addr_t o_mem_addr;
  word_t o_mem_data;
  logic  o_pc_enable;

  word_t       mem [0:2047];  // Program memory of the processor model.
  pc_t         pc_model;
  logic        m_wr;
  logic        m_en;
  logic        m_srst_n;
  addr_t       m_addr;
  word_t       m_data;
  logic [31:0] rng;
  logic        slow_credits;
  int          cycle_no;
  int          tb_cycles;     // Enabled cycles since the last load.
  int          outstanding;   // Bytes sent minus credits returned.
  int          n_write;
  int          n_en;
  int          n_srst;
  int          n_tx;
  byte_t       exp_q[$];
  addr_t       wr_addr_q[$];
  word_t       wr_data_q[$];
  int          credit_q[$];   // Cycle numbers at which credits go back.

  debug_unit #(
    .TX_CREDITS (TX_CREDITS)
  ) DUT (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_rx_valid    (i_rx_valid),
    .i_rx_data     (i_rx_data),
    .i_tx_credit   (i_tx_credit),
    .i_pc          (i_pc),
    .i_instruction (i_instruction),
    .o_tx_valid    (o_tx_valid),
    .o_tx_data     (o_tx_data),
    .o_soft_reset  (o_soft_reset),
    .o_mem_write   (o_mem_write),
    .o_mem_addr    (o_mem_addr),
    .o_mem_data    (o_mem_data),
    .o_pc_enable   (o_pc_enable)
  );

  always #20 i_clock = ~i_clock;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() % n);
  endfunction

  function automatic int credit_delay();
    return slow_credits ? 8 + rand_below(6) : rand_below(6);
  endfunction

  // Expected report: PC, cycle count, instruction, MSB first.
  function automatic report_t expected_report(input pc_t pc, input count_t cnt,
                                              input word_t instr);
    report_t r;
    r[0] = pc[15:8];
    r[1] = pc[7:0];
    r[2] = cnt[15:8];
    r[3] = cnt[7:0];
    r[4] = instr[31:24];
    r[5] = instr[23:16];
    r[6] = instr[15:8];
    r[7] = instr[7:0];
    return r;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic send_byte(input byte_t b, input int gap);
    repeat (gap) @(posedge i_clock);
    @(posedge i_clock);
    #1;
    i_rx_valid = 1'b1;
    i_rx_data  = b;
    @(posedge i_clock);
    #1;
    i_rx_valid = 1'b0;
  endtask

  task automatic wait_enable(input logic level);
    int t;
    t = 0;
    do begin
      @(negedge i_clock);
      t++;
      if (t > TIMEOUT) report_failure("Timed out waiting for the PC enable to change.");
    end while (o_pc_enable !== level);
  endtask

  task automatic wait_writes_done();
    int t;
    t = 0;
    while (wr_addr_q.size() != 0) begin
      @(negedge i_clock);
      t++;
      if (t > TIMEOUT) report_failure("Timed out waiting for the program memory writes.");
    end
  endtask

  task automatic wait_report_sent();
    int t;
    t = 0;
    while (exp_q.size() != 0) begin
      @(negedge i_clock);
      t++;
      if (t > TIMEOUT) report_failure("Timed out waiting for the report bytes.");
    end
  endtask

  task automatic load_program();
    word_t w;
    tb_cycles = 0;
    send_byte(CMD_LOAD, rand_below(6));
    for (int k = 0; k < 7; k++) begin
      if (k == 6) begin
        w = HALT_WORD;
      end else begin
        do w = next_rand(); while (w == HALT_WORD);  // Only the last word halts.
      end
      wr_addr_q.push_back(addr_t'(k));
      wr_data_q.push_back(w);
      for (int b = 3; b >= 0; b--) begin
        send_byte(w[8*b +: 8], rand_below(6));
      end
    end
    wait_writes_done();
    repeat (4) @(posedge i_clock);
  endtask

  task automatic soft_reset_check();
    int srst0;
    int wr0;
    int en0;
    int tx0;
    int t;
    srst0 = n_srst;
    wr0   = n_write;
    en0   = n_en;
    tx0   = n_tx;
    t     = 0;
    send_byte(CMD_SOFT_RESET, rand_below(6));
    while (n_srst == srst0) begin
      @(negedge i_clock);
      t++;
      if (t > TIMEOUT) report_failure("Timed out waiting for the soft reset pulse.");
    end
    repeat (4) @(negedge i_clock);
    assert (n_srst == srst0 + 1) else report_failure($sformatf(
      "** Error at %0t: o_soft_reset low cycles = %0d, expected 1", $time, n_srst - srst0));
    assert ((n_write == wr0) && (n_en == en0) && (n_tx == tx0))
      else report_failure("Soft reset caused a memory write, a PC enable or a transmit.");
  endtask

  task automatic run_command(input byte_t cmd, input int enables);
    int      en0;
    report_t r;
    en0 = n_en;
    send_byte(cmd, rand_below(6));
    wait_enable(1'b1);
    wait_enable(1'b0);
    r = expected_report(pc_model, count_t'(tb_cycles), mem[pc_model[10:0]]);
    for (int k = 0; k < REPORT_BYTES; k++) begin
      exp_q.push_back(r[k]);
    end
    wait_report_sent();
    repeat (3) @(posedge i_clock);  // Sequencer leaves ST_REPORT.
    assert (n_en - en0 == enables) else report_failure($sformatf(
      "** Error at %0t: o_pc_enable cycles = %0d, expected %0d", $time, n_en - en0, enables));
  endtask

  //////////////////////////////
  // Models and checkers
  //////////////////////////////

  always @(posedge i_clock) begin : cpu_model
    #1;
    if (m_wr) mem[m_addr] = m_data;
    if (!m_srst_n) begin
      pc_model = '0;
    end else if (m_en) begin
      pc_model = pc_model + 16'd1;
    end
    i_pc          = pc_model;
    i_instruction = mem[pc_model[10:0]];
  end

  always @(posedge i_clock) begin : credit_return
    #1;
    cycle_no++;
    if ((credit_q.size() != 0) && (credit_q[0] <= cycle_no)) begin
      i_tx_credit = 1'b1;
      void'(credit_q.pop_front());
    end else begin
      i_tx_credit = 1'b0;
    end
  end

  always @(negedge i_clock) begin : monitor
    m_wr     = o_mem_write && i_reset;
    m_addr   = o_mem_addr;
    m_data   = o_mem_data;
    m_en     = o_pc_enable && i_reset;
    m_srst_n = o_soft_reset || !i_reset;
    if (i_reset) begin
      if (o_mem_write) begin
        n_write++;
        assert (wr_addr_q.size() != 0) else report_failure("Unexpected program memory write.");
        assert (o_mem_addr == wr_addr_q[0]) else report_failure($sformatf(
          "** Error at %0t: o_mem_addr = %0d, expected %0d", $time, o_mem_addr, wr_addr_q[0]));
        assert (o_mem_data == wr_data_q[0]) else report_failure($sformatf(
          "** Error at %0t: o_mem_data = %h, expected %h", $time, o_mem_data, wr_data_q[0]));
        void'(wr_addr_q.pop_front());
        void'(wr_data_q.pop_front());
      end
      if (o_pc_enable) begin
        n_en++;
        tb_cycles++;
      end
      if (!o_soft_reset) n_srst++;
      if (o_tx_valid) begin
        n_tx++;
        outstanding++;
        credit_q.push_back(cycle_no + credit_delay());
      end
      if (i_tx_credit) outstanding--;
      assert (outstanding <= TX_CREDITS) else report_failure($sformatf(
        "** Error at %0t: outstanding bytes = %0d, limit %0d", $time, outstanding, TX_CREDITS));
    end
  end

  always @(negedge i_clock) begin : tx_checker
    if (i_reset && o_tx_valid) begin
      assert (exp_q.size() != 0) else report_failure("Report byte sent when none was expected.");
      assert (o_tx_data == exp_q[0]) else report_failure($sformatf(
        "** Error at %0t: o_tx_data = %h, expected %h", $time, o_tx_data, exp_q[0]));
      void'(exp_q.pop_front());
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int wr0;
    int en0;
    int tx0;
    i_clock       = 1'b0;
    i_reset       = 1'b0;
    i_rx_valid    = 1'b0;
    i_rx_data     = '0;
    i_tx_credit   = 1'b0;
    pc_model      = '0;
    i_pc          = '0;
    for (int k = 0; k < 2048; k++) begin
      mem[k] = 32'hC0DE_0000 | k;  // Nonzero, unique per word.
    end
    i_instruction = mem[0];
    m_wr          = 1'b0;
    m_en          = 1'b0;
    m_srst_n      = 1'b1;
    m_addr        = '0;
    m_data        = '0;
    rng           = 32'd27;
    slow_credits  = 1'b0;
    cycle_no      = 0;
    tb_cycles     = 0;
    outstanding   = 0;
    n_write       = 0;
    n_en          = 0;
    n_srst        = 0;
    n_tx          = 0;
    repeat (10) @(posedge i_clock);
    #1;
    i_reset = 1'b1;
    repeat (3) @(posedge i_clock);

    // Stray bytes and start commands before any load.
    wr0 = n_write;
    en0 = n_en;
    tx0 = n_tx;
    send_byte(8'h55, rand_below(6));
    send_byte(CMD_RUN_CONT, rand_below(6));
    send_byte(CMD_RUN_STEP, rand_below(6));
    send_byte(8'hFF, rand_below(6));
    repeat (6) @(negedge i_clock);
    assert ((n_write == wr0) && (n_en == en0) && (n_tx == tx0))
      else report_failure("An ignored byte caused a memory write, a PC enable or a transmit.");

    soft_reset_check();
    load_program();
    run_command(CMD_RUN_CONT, 6);
    assert (pc_model == 16'd6) else report_failure($sformatf(
      "** Error at %0t: i_pc = %0d, expected 6", $time, pc_model));

    // Reload and step with slow credits.
    soft_reset_check();
    load_program();
    slow_credits = 1'b1;
    for (int s = 1; s <= 6; s++) begin
      run_command(CMD_RUN_STEP, 1);
      assert (pc_model == pc_t'(s)) else report_failure($sformatf(
        "** Error at %0t: i_pc = %0d, expected %0d", $time, pc_model, s));
    end

    en0 = n_en;
    send_byte(CMD_RUN_STEP, 0);  // Unit is idle after HALT.
    repeat (8) @(negedge i_clock);
    assert (n_en == en0) else report_failure("A step command after HALT enabled the PC.");

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
verilog/debug_pkg.sv
verilog/load_if.sv
verilog/report_if.sv
verilog/program_loader.sv
verilog/report_serializer.sv
verilog/debug_sequencer.sv
verilog/debug_unit.sv
verif/tb_debug_unit.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_debug_unit -f vlog.f

./obj_dir/Vtb_debug_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed."
  exit 1
fi
